// ==== run.sh ====
#!/usr/bin/env bash
# Builds the weight rotator testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
  --top-module tb_weight_rotator -f weight_rotator.f -o sim_weight_rotator \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/sim_weight_rotator > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// ==== source/weight_bank_if.sv ====
/* Bank write and bank read channels between the loader, the bank store
   and the output sequencer. */
`timescale 1ns/1ns
`default_nettype none

interface bank_write_if;
  logic                                        wr_start;  // Pulse, header is valid.
  weight_rotator_pkg::weight_header_t          wr_header;
  logic                                        wr_en;
  logic [weight_rotator_pkg::BITS_ADDR-1:0]    wr_addr;
  logic [weight_rotator_pkg::BEAT_WIDTH-1:0]   wr_data;
  logic                                        wr_commit; // Pulse, bank is complete.
  logic                                        wr_free;

  modport loader (output wr_start, wr_header, wr_en, wr_addr, wr_data, wr_commit,
                  input  wr_free);
  modport store  (input  wr_start, wr_header, wr_en, wr_addr, wr_data, wr_commit,
                  output wr_free);
endinterface

interface bank_read_if;
  logic                                        rd_full;
  weight_rotator_pkg::weight_header_t          rd_header;
  logic [weight_rotator_pkg::BEAT_WIDTH-1:0]   rd_data;
  logic [weight_rotator_pkg::BITS_ADDR-1:0]    rd_addr;
  logic                                        rd_release; // Pulse, bank may be reused.

  modport store     (output rd_full, rd_header, rd_data,
                     input  rd_addr, rd_release);
  modport sequencer (input  rd_full, rd_header, rd_data,
                     output rd_addr, rd_release);
endinterface

`default_nettype wire

// ==== source/weight_bank_store.sv ====
/* Ping-pong bank store: two weight memories with their header registers,
   full flags and the write and read bank pointers. */
`timescale 1ns/1ns
`default_nettype none

module weight_bank_store (
  input  wire logic aclk,
  input  wire logic i_reset,
  bank_write_if.store wr,
  bank_read_if.store  rd
);

  logic [weight_rotator_pkg::BEAT_WIDTH-1:0] mem [2][weight_rotator_pkg::BANK_DEPTH];
  weight_rotator_pkg::weight_header_t        hdr [2];

  logic [1:0] full_q;
  logic [1:0] full_next;
  logic       wr_ptr_q;
  logic       wr_ptr_next;
  logic       rd_ptr_q;
  logic       rd_ptr_next;
  logic       free_q;

  // A commit fills the write bank and a release empties the read bank.
  // They never land on the same bank, since only a full bank is read.
  always_comb begin
    full_next = full_q;
    if (wr.wr_commit) begin
      full_next[wr_ptr_q] = 1'b1;
    end
    if (rd.rd_release) begin
      full_next[rd_ptr_q] = 1'b0;
    end
    wr_ptr_next = wr_ptr_q ^ wr.wr_commit;
    rd_ptr_next = rd_ptr_q ^ rd.rd_release;
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      full_q   <= 2'b00;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      free_q   <= 1'b0;   // Rises one cycle after reset ends.
    end else begin
      full_q   <= full_next;
      wr_ptr_q <= wr_ptr_next;
      rd_ptr_q <= rd_ptr_next;
      free_q   <= !full_next[wr_ptr_next];
    end
  end

  assign wr.wr_free = free_q;

  // The header is taken with the start pulse, the words as they arrive.
  always_ff @(posedge aclk) begin
    if (wr.wr_start) begin
      hdr[wr_ptr_q] <= wr.wr_header;
    end
    if (wr.wr_en) begin
      mem[wr_ptr_q][wr.wr_addr] <= wr.wr_data;
    end
  end

  // Read side is combinational from the sequencer's registered address.
  assign rd.rd_full   = full_q[rd_ptr_q];
  assign rd.rd_header = hdr[rd_ptr_q];
  assign rd.rd_data   = mem[rd_ptr_q][rd.rd_addr];

endmodule

`default_nettype wire

// ==== source/weight_loader.sv ====
/* Weight loader: takes the header beat of each packet, then writes the
   configuration and weight beats into the current write bank. */
`timescale 1ns/1ns
`default_nettype none

module weight_loader (
  input  wire logic                             aclk,
  input  wire logic                             i_reset,
  input  wire logic                             i_s_valid,
  input  wire weight_rotator_pkg::weight_beat_u i_s_data,
  input  wire logic                             i_s_last,
  output logic                                  o_s_ready,
  bank_write_if.loader                          wr
);

  typedef enum logic {
    S_HEADER,
    S_DATA
  } state_t;

  state_t                                   state_q;
  logic [weight_rotator_pkg::BITS_ADDR-1:0] addr_q;
  logic                                     commit_q;
  logic                                     s_handshake;
  logic                                     in_header;

  assign in_header = (state_q == S_HEADER);

  // The store only sees the new write bank the cycle after the commit,
  // so a header is held off while the commit is in flight.
  assign o_s_ready   = in_header ? (wr.wr_free && !commit_q) : 1'b1;
  assign s_handshake = i_s_valid && o_s_ready;

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      state_q  <= S_HEADER;
      commit_q <= 1'b0;
    end else begin
      commit_q <= s_handshake && !in_header && i_s_last;
      case (state_q)
        S_HEADER: if (s_handshake) state_q <= S_DATA;
        S_DATA:   if (s_handshake && i_s_last) state_q <= S_HEADER;
        default:  state_q <= S_HEADER;
      endcase
    end
  end

  // Config and weight beats fill the bank from address zero.
  always_ff @(posedge aclk) begin
    if (i_reset) begin
      addr_q <= '0;
    end else if (wr.wr_start) begin
      addr_q <= '0;
    end else if (wr.wr_en) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  assign wr.wr_start  = s_handshake && in_header;
  assign wr.wr_header = i_s_data.header.fields; // Header view of the first beat.
  assign wr.wr_en     = s_handshake && !in_header;
  assign wr.wr_addr   = addr_q;
  assign wr.wr_data   = i_s_data.data;
  assign wr.wr_commit = commit_q;

endmodule

`default_nettype wire

// ==== source/weight_rotator.sv ====
/* Weight rotator top level: a loader, a ping-pong bank store and an output
   sequencer joined by the bank write and read channels. */
`timescale 1ns/1ns
`default_nettype none

module weight_rotator (
  input  wire logic                                  aclk,
  input  wire logic                                  i_reset,

  input  wire logic                                  i_s_valid,
  output logic                                       o_s_ready,
  input  wire logic [weight_rotator_pkg::BEAT_WIDTH-1:0] i_s_data,
  input  wire logic                                  i_s_last,

  output logic                                       o_m_valid,
  input  wire logic                                  i_m_ready,
  output logic [weight_rotator_pkg::BEAT_WIDTH-1:0]  o_m_data,
  output logic                                       o_m_last,
  output logic [weight_rotator_pkg::TUSER_WIDTH-1:0] o_m_user
);

  weight_rotator_pkg::weight_beat_u s_beat;

  bank_write_if u_bank_write ();
  bank_read_if  u_bank_read ();

  assign s_beat = i_s_data;  // The loader decodes the beat as header or data.

  weight_loader u_weight_loader (
    .aclk      (aclk),
    .i_reset   (i_reset),
    .i_s_valid (i_s_valid),
    .i_s_data  (s_beat),
    .i_s_last  (i_s_last),
    .o_s_ready (o_s_ready),
    .wr        (u_bank_write.loader)
  );

  weight_bank_store u_weight_bank_store (
    .aclk    (aclk),
    .i_reset (i_reset),
    .wr      (u_bank_write.store),
    .rd      (u_bank_read.store)
  );

  weight_sequencer u_weight_sequencer (
    .aclk      (aclk),
    .i_reset   (i_reset),
    .rd        (u_bank_read.sequencer),
    .i_m_ready (i_m_ready),
    .o_m_valid (o_m_valid),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .o_m_user  (o_m_user)
  );

endmodule

`default_nettype wire

// ==== source/weight_rotator_pkg.sv ====
/* Weight rotator shared definitions: sizes, header layout, input beat views
   and output sideband bit positions. */
`default_nettype none

package weight_rotator_pkg;

  localparam int WORD_WIDTH    = 8;
  localparam int CORES         = 2;
  localparam int KERNEL_W_MAX  = 3;
  localparam int KERNEL_H_MAX  = 3;
  localparam int BEAT_WIDTH    = WORD_WIDTH * CORES * KERNEL_W_MAX;
  localparam int IM_CIN_MAX    = 16;
  localparam int IM_COLS_MAX   = 32;
  localparam int IM_BLOCKS_MAX = 8;

  // Every dimension travels as value minus one.
  localparam int BITS_KW     = $clog2(KERNEL_W_MAX);
  localparam int BITS_KH     = $clog2(KERNEL_H_MAX);
  localparam int BITS_CIN    = $clog2(IM_CIN_MAX);
  localparam int BITS_COLS   = $clog2(IM_COLS_MAX);
  localparam int BITS_BLOCKS = $clog2(IM_BLOCKS_MAX);

  localparam int BEATS_CONFIG_3X3 = 5;
  localparam int BEATS_CONFIG_1X1 = 3;
  localparam int BITS_CONFIG      = $clog2(BEATS_CONFIG_3X3); // Holds count minus one.

  localparam int BANK_DEPTH = 64;
  localparam int BITS_ADDR  = $clog2(BANK_DEPTH);

  localparam int I_IS_TOP_BLOCK    = 0;
  localparam int I_IS_BOTTOM_BLOCK = 1;
  localparam int I_IS_1X1          = 2;
  localparam int I_IS_COLS_1_K2    = 3;
  localparam int I_IS_CONFIG       = 4;
  localparam int I_KERNEL_W_1      = 5;
  localparam int TUSER_WIDTH       = I_KERNEL_W_1 + BITS_KW;

  typedef struct packed {
    logic [BITS_BLOCKS-1:0] blocks_1;
    logic [BITS_COLS-1:0]   cols_1;
    logic [BITS_CIN-1:0]    cin_1;
    logic [BITS_KH-1:0]     kh_1;
    logic [BITS_KW-1:0]     kw_1;
  } weight_header_t;

  localparam int HEADER_WIDTH = BITS_BLOCKS + BITS_COLS + BITS_CIN + BITS_KH + BITS_KW;

  // The first beat of a packet is a header, the rest are raw words.
  typedef union packed {
    struct packed {
      logic [BEAT_WIDTH-HEADER_WIDTH-1:0] spare;
      weight_header_t                     fields;
    } header;
    logic [BEAT_WIDTH-1:0] data;
  } weight_beat_u;

endpackage

`default_nettype wire

// ==== source/weight_sequencer.sv ====
/* Weight sequencer: sends the configuration beats of a full bank once, then
   rotates its weight beats cols x blocks times with sideband flags. */
`timescale 1ns/1ns
`default_nettype none

module weight_sequencer (
  input  wire logic                                      aclk,
  input  wire logic                                      i_reset,
  bank_read_if.sequencer                                 rd,
  input  wire logic                                      i_m_ready,
  output logic                                           o_m_valid,
  output logic [weight_rotator_pkg::BEAT_WIDTH-1:0]      o_m_data,
  output logic                                           o_m_last,
  output logic [weight_rotator_pkg::TUSER_WIDTH-1:0]     o_m_user
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CONFIG,
    S_ROTATE,
    S_RELEASE
  } state_t;

  state_t                                     state_q;
  weight_rotator_pkg::weight_header_t         hdr;
  logic [weight_rotator_pkg::BITS_ADDR-1:0]   base_addr;
  logic [weight_rotator_pkg::BITS_ADDR-1:0]   addr_q;
  logic [weight_rotator_pkg::BITS_CONFIG-1:0] cfg_cnt;
  logic [weight_rotator_pkg::BITS_KH-1:0]     kh_cnt;
  logic [weight_rotator_pkg::BITS_CIN-1:0]    cin_cnt;
  logic [weight_rotator_pkg::BITS_COLS-1:0]   cols_cnt;
  logic [weight_rotator_pkg::BITS_BLOCKS-1:0] blocks_cnt;
  logic                                       last_kh;
  logic                                       last_cin;
  logic                                       last_cols;
  logic                                       last_blocks;
  logic                                       pass_end;
  logic                                       last_beat;
  logic                                       rotating;
  logic                                       m_handshake;

  assign hdr = rd.rd_header;

  // Weights sit right after the config beats, whose count is set by kh.
  assign base_addr = (hdr.kh_1 == '0) ?
                     weight_rotator_pkg::BITS_ADDR'(weight_rotator_pkg::BEATS_CONFIG_1X1) :
                     weight_rotator_pkg::BITS_ADDR'(weight_rotator_pkg::BEATS_CONFIG_3X3);

  assign last_kh     = (kh_cnt == '0);
  assign last_cin    = (cin_cnt == '0);
  assign last_cols   = (cols_cnt == '0);
  assign last_blocks = (blocks_cnt == '0);
  assign pass_end    = last_kh && last_cin;   // End of one kh x cin pass.
  assign last_beat   = pass_end && last_cols && last_blocks;

  assign rotating    = (state_q == S_ROTATE);
  assign o_m_valid   = (state_q == S_CONFIG) || rotating;
  assign m_handshake = o_m_valid && i_m_ready;

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      state_q    <= S_IDLE;
      addr_q     <= '0;
      cfg_cnt    <= '0;
      kh_cnt     <= '0;
      cin_cnt    <= '0;
      cols_cnt   <= '0;
      blocks_cnt <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (rd.rd_full) begin
            state_q    <= S_CONFIG;
            addr_q     <= '0;
            cfg_cnt    <= weight_rotator_pkg::BITS_CONFIG'(base_addr - 1'b1);
            kh_cnt     <= hdr.kh_1;
            cin_cnt    <= hdr.cin_1;
            cols_cnt   <= hdr.cols_1;
            blocks_cnt <= hdr.blocks_1;
          end
        end
        S_CONFIG: begin
          if (m_handshake) begin
            addr_q <= addr_q + 1'b1; // Lands on base_addr after the last one.
            if (cfg_cnt == '0) begin
              state_q <= S_ROTATE;
            end else begin
              cfg_cnt <= cfg_cnt - 1'b1;
            end
          end
        end
        S_ROTATE: begin
          if (m_handshake) begin
            if (last_beat) begin
              state_q <= S_RELEASE;
            end
            addr_q <= pass_end ? base_addr : addr_q + 1'b1;
            kh_cnt <= last_kh ? hdr.kh_1 : kh_cnt - 1'b1;
            if (last_kh) begin
              cin_cnt <= last_cin ? hdr.cin_1 : cin_cnt - 1'b1;
            end
            if (pass_end) begin
              cols_cnt <= last_cols ? hdr.cols_1 : cols_cnt - 1'b1;
            end
            if (pass_end && last_cols) begin
              blocks_cnt <= last_blocks ? hdr.blocks_1 : blocks_cnt - 1'b1;
            end
          end
        end
        default: begin
          state_q <= S_IDLE;  // Release takes one cycle.
        end
      endcase
    end
  end

  assign rd.rd_addr    = addr_q;
  assign rd.rd_release = (state_q == S_RELEASE);

  assign o_m_data = rd.rd_data;
  assign o_m_last = rotating && last_beat;

  // Config beats carry only the config flag.
  assign o_m_user[weight_rotator_pkg::I_IS_CONFIG]       = (state_q == S_CONFIG);
  assign o_m_user[weight_rotator_pkg::I_IS_1X1]          = rotating && (hdr.kw_1 == '0);
  assign o_m_user[weight_rotator_pkg::I_IS_TOP_BLOCK]    = rotating && (blocks_cnt == hdr.blocks_1);
  assign o_m_user[weight_rotator_pkg::I_IS_BOTTOM_BLOCK] = rotating && last_blocks;
  // Column cols-1-kw/2 counted from the left is kw/2 on the down-counter.
  assign o_m_user[weight_rotator_pkg::I_IS_COLS_1_K2] =
      rotating && (cols_cnt == weight_rotator_pkg::BITS_COLS'(hdr.kw_1 >> 1));
  assign o_m_user[weight_rotator_pkg::I_KERNEL_W_1 +: weight_rotator_pkg::BITS_KW] =
      rotating ? hdr.kw_1 : '0;

endmodule

`default_nettype wire

// ==== tb/rotator_checker.sv ====
/* Rotator checker: captures each accepted input packet, predicts the output
   stream from the rotation rules and compares it beat by beat. */
`timescale 1ns/1ns
`default_nettype none

module rotator_checker #(
  parameter int NUM_PACKETS = 1
) (
  input  wire logic                                       aclk,
  input  wire logic                                       i_reset,
  input  wire logic                                       i_s_valid,
  input  wire logic                                       i_s_ready,
  input  wire logic [weight_rotator_pkg::BEAT_WIDTH-1:0]  i_s_data,
  input  wire logic                                       i_s_last,
  input  wire logic                                       i_m_valid,
  input  wire logic                                       i_m_ready,
  input  wire logic [weight_rotator_pkg::BEAT_WIDTH-1:0]  i_m_data,
  input  wire logic                                       i_m_last,
  input  wire logic [weight_rotator_pkg::TUSER_WIDTH-1:0] i_m_user,
  output logic                                            o_done,
  output logic [31:0]                                     o_errors
);

  logic [weight_rotator_pkg::BEAT_WIDTH-1:0]  exp_data [$];
  logic [weight_rotator_pkg::TUSER_WIDTH-1:0] exp_user [$];
  logic                                       exp_last [$];
  logic [weight_rotator_pkg::BEAT_WIDTH-1:0]  in_words [$];  // Config then weight words.
  weight_rotator_pkg::weight_header_t         in_hdr;
  weight_rotator_pkg::weight_beat_u           in_beat;
  logic                                       in_packet;
  logic                                       held;
  logic [weight_rotator_pkg::BEAT_WIDTH-1:0]  held_data;
  logic [weight_rotator_pkg::TUSER_WIDTH-1:0] held_user;
  logic                                       held_last;
  int                                         packets_out;
  int                                         beats_out;
  int                                         pkt_beats;
  int                                         pkt_errors;
  int                                         errors;

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Fail at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
      errors++;
      pkt_errors++;
    end
  endtask

  // Config words pass once, then the kh x cin weight block repeats per column and block.
  task automatic predict_packet();
    int                                         cfg_n;
    int                                         n_w;
    logic [weight_rotator_pkg::TUSER_WIDTH-1:0] flags;
    cfg_n = (in_hdr.kh_1 != 0) ? weight_rotator_pkg::BEATS_CONFIG_3X3 :
                                 weight_rotator_pkg::BEATS_CONFIG_1X1;
    n_w = in_words.size() - cfg_n;
    for (int i = 0; i < cfg_n; i++) begin
      flags = '0;
      flags[weight_rotator_pkg::I_IS_CONFIG] = 1'b1;
      exp_data.push_back(in_words[i]);
      exp_user.push_back(flags);
      exp_last.push_back(1'b0);
    end
    for (int b = int'(in_hdr.blocks_1); b >= 0; b--) begin
      for (int c = int'(in_hdr.cols_1); c >= 0; c--) begin
        for (int j = 0; j < n_w; j++) begin
          flags = '0;
          flags[weight_rotator_pkg::I_IS_TOP_BLOCK]    = (b == int'(in_hdr.blocks_1));
          flags[weight_rotator_pkg::I_IS_BOTTOM_BLOCK] = (b == 0);
          flags[weight_rotator_pkg::I_IS_1X1]          = (in_hdr.kw_1 == 0);
          flags[weight_rotator_pkg::I_IS_COLS_1_K2]    = (c == int'(in_hdr.kw_1) / 2);
          flags[weight_rotator_pkg::I_KERNEL_W_1 +: weight_rotator_pkg::BITS_KW] = in_hdr.kw_1;
          exp_data.push_back(in_words[cfg_n + j]);
          exp_user.push_back(flags);
          exp_last.push_back((b == 0) && (c == 0) && (j == n_w - 1));
        end
      end
    end
    in_words.delete();
  endtask

  task automatic check_beat();
    logic last_exp;
    if (exp_data.size() == 0) begin
      $display("Error at %0t ns: an output beat came with no packet pending", $time);
      errors++;
    end else begin
      last_exp = exp_last.pop_front();
      compare_value("o_m_data", exp_data.pop_front(), i_m_data);
      compare_value("o_m_user", exp_user.pop_front(), i_m_user);
      compare_value("o_m_last", last_exp, i_m_last);
      pkt_beats++;
      beats_out++;
      if (last_exp) begin
        $display("Packet %0d done: %0d beats, %0d errors", packets_out, pkt_beats, pkt_errors);
        packets_out++;
        pkt_beats  = 0;
        pkt_errors = 0;
        if (packets_out == NUM_PACKETS) begin
          $display("Checked %0d packets, %0d beats, %0d errors", packets_out, beats_out, errors);
          o_done <= 1'b1;
        end
      end
    end
  endtask

  always @(posedge aclk) begin
    if (i_reset) begin
      in_packet   = 1'b0;
      held        = 1'b0;
      packets_out = 0;
      beats_out   = 0;
      pkt_beats   = 0;
      pkt_errors  = 0;
      errors      = 0;
      o_done   <= 1'b0;
      o_errors <= '0;
    end else begin
      // Once a header is in, every offered beat up to the last one is taken at once.
      if (in_packet && i_s_valid) begin
        compare_value("o_s_ready", 64'd1, i_s_ready);
      end
      if (i_s_valid && i_s_ready) begin
        in_beat = i_s_data;
        if (!in_packet) begin
          in_hdr    = in_beat.header.fields;  // First beat of a packet is the header.
          in_packet = 1'b1;
        end else begin
          in_words.push_back(in_beat.data);
          if (i_s_last) begin
            predict_packet();
            in_packet = 1'b0;
          end
        end
      end
      // A stalled output beat must stay put until it is taken.
      if (held) begin
        compare_value("o_m_valid", 64'd1, i_m_valid);
        compare_value("o_m_data", held_data, i_m_data);
        compare_value("o_m_user", held_user, i_m_user);
        compare_value("o_m_last", held_last, i_m_last);
      end
      held      = i_m_valid && !i_m_ready;
      held_data = i_m_data;
      held_user = i_m_user;
      held_last = i_m_last;
      if (i_m_valid && i_m_ready) begin
        check_beat();
      end
      o_errors <= errors;
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_weight_rotator.sv ====
/* Weight rotator testbench: sends a table of packets with LFSR weights under
   random output back-pressure, with a checker and a watchdog. */
`timescale 1ns/1ns
`default_nettype none

module tb_weight_rotator;

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 3;
  localparam int          NUM_PACKETS  = 6;
  localparam logic [15:0] LFSR_SEED    = 16'd27;
  localparam logic [15:0] LFSR_TAPS    = 16'hB400;  // Maximal length 16-bit polynomial.

  typedef struct packed {
    int kw_1;
    int kh_1;
    int cin_1;
    int cols_1;
    int blocks_1;
    bit stall;
  } packet_cfg_t;

  // Columns: kw_1, kh_1, cin_1, cols_1, blocks_1, idle cycle before each input beat.
  localparam packet_cfg_t PACKETS [NUM_PACKETS] = '{
    '{2, 2, 1,  3, 1, 1'b0},
    '{0, 0, 3,  2, 0, 1'b1},
    '{2, 2, 0,  4, 2, 1'b0},
    '{1, 1, 2,  1, 1, 1'b1},
    '{0, 0, 7,  0, 0, 1'b0},
    '{2, 2, 15, 1, 0, 1'b0}
  };

  logic                                       aclk = 1'b0;
  logic                                       i_reset;
  logic                                       i_s_valid;
  logic                                       o_s_ready;
  logic [weight_rotator_pkg::BEAT_WIDTH-1:0]  i_s_data;
  logic                                       i_s_last;
  logic                                       o_m_valid;
  logic                                       i_m_ready = 1'b0;
  logic [weight_rotator_pkg::BEAT_WIDTH-1:0]  o_m_data;
  logic                                       o_m_last;
  logic [weight_rotator_pkg::TUSER_WIDTH-1:0] o_m_user;
  logic                                       checks_done;
  logic [31:0]                                check_errors;
  logic [15:0]                                lfsr;
  logic [weight_rotator_pkg::BEAT_WIDTH-1:0]  ready_bits;
  logic [weight_rotator_pkg::BEAT_WIDTH-1:0]  stim_data [$];
  logic                                       stim_last [$];
  logic                                       stim_stall [$];

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  weight_rotator u_weight_rotator (
    .aclk      (aclk),
    .i_reset   (i_reset),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .o_m_user  (o_m_user)
  );

  rotator_checker #(.NUM_PACKETS(NUM_PACKETS)) u_rotator_checker (
    .aclk (aclk), .i_reset (i_reset),
    .i_s_valid (i_s_valid), .i_s_ready (o_s_ready), .i_s_data (i_s_data), .i_s_last (i_s_last),
    .i_m_valid (o_m_valid), .i_m_ready (i_m_ready), .i_m_data (o_m_data), .i_m_last (o_m_last),
    .i_m_user (o_m_user), .o_done (checks_done), .o_errors (check_errors)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
  endfunction

  task automatic draw_bits(input int count, output logic [weight_rotator_pkg::BEAT_WIDTH-1:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[weight_rotator_pkg::BEAT_WIDTH-2:0], lfsr[0]};  // One step per bit.
    end
  endtask

  function automatic int config_beats(input int kh_1);
    return (kh_1 != 0) ? weight_rotator_pkg::BEATS_CONFIG_3X3 : weight_rotator_pkg::BEATS_CONFIG_1X1;
  endfunction

  function automatic int output_beats(input packet_cfg_t p);
    return config_beats(p.kh_1) + (p.kh_1 + 1) * (p.cin_1 + 1) * (p.cols_1 + 1) * (p.blocks_1 + 1);
  endfunction

  // Every input beat is drawn up front, so back-pressure owns the LFSR afterwards.
  task automatic build_stimulus();
    weight_rotator_pkg::weight_beat_u          beat;
    logic [weight_rotator_pkg::BEAT_WIDTH-1:0] word;
    int                                        n_words;
    for (int p = 0; p < NUM_PACKETS; p++) begin
      beat.data = '0;
      beat.header.fields.kw_1     = weight_rotator_pkg::BITS_KW'(PACKETS[p].kw_1);
      beat.header.fields.kh_1     = weight_rotator_pkg::BITS_KH'(PACKETS[p].kh_1);
      beat.header.fields.cin_1    = weight_rotator_pkg::BITS_CIN'(PACKETS[p].cin_1);
      beat.header.fields.cols_1   = weight_rotator_pkg::BITS_COLS'(PACKETS[p].cols_1);
      beat.header.fields.blocks_1 = weight_rotator_pkg::BITS_BLOCKS'(PACKETS[p].blocks_1);
      stim_data.push_back(beat.data);
      stim_last.push_back(1'b0);
      stim_stall.push_back(PACKETS[p].stall);
      n_words = config_beats(PACKETS[p].kh_1) + (PACKETS[p].kh_1 + 1) * (PACKETS[p].cin_1 + 1);
      for (int i = 0; i < n_words; i++) begin
        draw_bits(weight_rotator_pkg::BEAT_WIDTH, word);
        stim_data.push_back(word);
        stim_last.push_back(i == n_words - 1);
        stim_stall.push_back(PACKETS[p].stall);
      end
    end
  endtask

  task automatic send_beat(input logic [weight_rotator_pkg::BEAT_WIDTH-1:0] data,
                           input logic last, input logic stall);
    if (stall) begin
      @(negedge aclk);
      i_s_valid = 1'b0;
    end
    @(negedge aclk);
    i_s_valid = 1'b1;
    i_s_data  = data;
    i_s_last  = last;
    while (!o_s_ready) begin
      @(negedge aclk);  // Ready only moves after a rising edge.
    end
  endtask

  always @(negedge aclk) begin
    if (!i_reset) begin
      draw_bits(1, ready_bits);
      i_m_ready <= ready_bits[0];
    end
  end

  initial begin
    lfsr      = LFSR_SEED;
    i_reset   = 1'b1;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    build_stimulus();
    repeat (RESET_CYCLES) @(posedge aclk);
    @(negedge aclk);
    i_reset <= 1'b0;
    for (int k = 0; k < stim_data.size(); k++) begin
      send_beat(stim_data[k], stim_last[k], stim_stall[k]);
    end
    @(negedge aclk);
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
    wait (checks_done === 1'b1);
    if (check_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    int limit_ns;
    limit_ns = 0;
    for (int p = 0; p < NUM_PACKETS; p++) begin
      limit_ns += (output_beats(PACKETS[p]) * 8 + 50) * CLK_PERIOD;
    end
    repeat (RESET_CYCLES) @(posedge aclk);
    #(limit_ns);
    $display("Timeout: the output stream did not finish within %0d ns", limit_ns);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== weight_rotator.f ====
source/weight_rotator_pkg.sv
source/weight_bank_if.sv
source/weight_loader.sv
source/weight_bank_store.sv
source/weight_sequencer.sv
source/weight_rotator.sv
tb/rotator_checker.sv
tb/tb_weight_rotator.sv
